/* all.f */
+incdir+include
src/pix_pkg.sv
src/code_pkg.sv
src/code_if.sv
src/window_3x3.sv
src/median_filter.sv
src/lbp_coder.sv
src/joint_histogram.sv
src/hist_reader.sv
src/texture_top.sv
sim/texture_tb.sv

/* include/texture_params.svh */
`ifndef TEXTURE_PARAMS_SVH
`define TEXTURE_PARAMS_SVH

// Image geometry
`define IMG_COLS 16
`define IMG_ROWS 16

`define PIX_W 8
`define CNT_W 16      // Bin counter width, saturating
`define RIU2_CODES 10 // 0..8 uniform by ones count, 9 non-uniform

`endif

/* run.sh */
#!/usr/bin/env bash
# Build and run the texture engine testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f all.f --top-module texture_tb \
  -o texture_sim > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/texture_sim > sim.log 2>&1
cat sim.log

grep -q "^All checks passed$" sim.log && exit 0 || exit 1

/* sim/texture_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "texture_params.svh"

module texture_tb;
  import pix_pkg::*;
  import code_pkg::*;

  localparam int MR = `IMG_ROWS - 2; // Median image size
  localparam int MC = `IMG_COLS - 2;
  localparam int NBINS = 2 * `RIU2_CODES * `RIU2_CODES;
  localparam int WAIT_LIMIT = 2000;
  localparam int CLEAR_CYCLES = 2 ** BIN_W;

  logic       clk = 1'b0;
  logic       rst_n;
  pixel_t     pixel_i;
  logic       pixel_valid_i;
  logic       start_i;
  logic       read_en_i;
  logic       ready_o;
  logic       frame_done_o;
  joint_bin_u bin_o;
  count_t     count_o;
  logic       hist_valid_o;
  logic       read_done_o;

  pixel_t     img [`IMG_ROWS][`IMG_COLS];
  count_t     exp_hist [2 ** BIN_W];
  string      test_name = "reset";
  logic       en_q = 1'b0;  // read_en_i seen at the last rising edge
  logic       done_due = 1'b0;
  int         bin_idx = 0;
  int         reads_done = 0;
  count_t     frame_sum = '0;
  joint_bin_u exp_bin;

  always #5 clk = ~clk;

  texture_top u_dut (
    .clk, .rst_n, .pixel_i, .pixel_valid_i, .start_i, .read_en_i, .ready_o, .frame_done_o,
    .bin_o, .count_o, .hist_valid_o, .read_done_o
  );

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Checks failed");
    $fatal(1, "Stopping at first error");
  endtask

  task automatic check_bin(input joint_bin_u exp, input joint_bin_u act);
    if (act !== exp) begin
      report_failure($sformatf("CHECK FAILED %s bin_o expected %0d actual %0d",
                               test_name, exp.addr, act.addr));
    end
  endtask

  task automatic check_count(input string what, input count_t exp, input count_t act);
    if (act !== exp) begin
      report_failure($sformatf("CHECK FAILED %s %s expected %0d actual %0d",
                               test_name, what, exp, act));
    end
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      report_failure($sformatf("CHECK FAILED %s %s expected %0b actual %0b",
                               test_name, what, exp, act));
    end
  endtask

  function automatic pixel_t median_of(input window_t w);
    pixel_t s [9];
    pixel_t t;
    for (int i = 0; i < 9; i++) begin
      s[i] = w[i];
    end
    for (int i = 0; i < 8; i++) begin
      for (int j = 0; j < 8 - i; j++) begin
        if (s[j] > s[j+1]) begin
          t = s[j];
          s[j] = s[j+1];
          s[j+1] = t;
        end
      end
    end
    return s[4];
  endfunction

  // At most two flips around the circle gives the ones count, else 9
  function automatic riu2_t uniform_code(input logic [7:0] pat);
    int ones;
    int flips;
    ones = 0;
    flips = 0;
    for (int k = 0; k < 8; k++) begin
      ones += int'(pat[k]);
      if (pat[k] != pat[(k + 1) % 8]) flips++;
    end
    return (flips <= 2) ? riu2_t'(ones) : riu2_t'(`RIU2_CODES - 1);
  endfunction

  function automatic void build_reference();
    pixel_t     med [MR][MC];
    window_t    w;
    pixel_t     nb [8];
    pixel_t     ctr;
    pixel_t     mean;
    int         sum;
    logic [7:0] ni_pat;
    logic [7:0] rd_pat;
    joint_bin_u b;
    foreach (exp_hist[a]) exp_hist[a] = '0;
    for (int r = 0; r < MR; r++) begin
      for (int c = 0; c < MC; c++) begin
        for (int k = 0; k < 9; k++) w[k] = img[r + k / 3][c + k % 3];
        med[r][c] = median_of(w);
      end
    end
    for (int r = 1; r < MR - 1; r++) begin
      for (int c = 1; c < MC - 1; c++) begin
        nb[0] = med[r-1][c-1];  // Clockwise from top left
        nb[1] = med[r-1][c];
        nb[2] = med[r-1][c+1];
        nb[3] = med[r][c+1];
        nb[4] = med[r+1][c+1];
        nb[5] = med[r+1][c];
        nb[6] = med[r+1][c-1];
        nb[7] = med[r][c-1];
        ctr = med[r][c];
        sum = 0;
        for (int k = 0; k < 8; k++) sum += int'(nb[k]);
        mean = pixel_t'(sum / 8);
        for (int k = 0; k < 8; k++) begin
          ni_pat[k] = nb[k] >= mean;
          rd_pat[k] = nb[k] >= ctr;
        end
        b.f.ci = ctr >= mean;
        b.f.ni = uniform_code(ni_pat);
        b.f.rd = uniform_code(rd_pat);
        exp_hist[b.addr] = exp_hist[b.addr] + 1'b1;
      end
    end
  endfunction

  function automatic void fill_image(input bit random_pix, input pixel_t level);
    foreach (img[r, c]) img[r][c] = random_pix ? pixel_t'($urandom) : level;
  endfunction

  // A flat interior gives all neighbour bits set and ci set
  function automatic void expect_flat();
    joint_bin_u b;
    foreach (exp_hist[a]) exp_hist[a] = '0;
    b.f.ci = 1'b1;
    b.f.ni = 4'd8;
    b.f.rd = 4'd8;
    exp_hist[b.addr] = count_t'((MR - 2) * (MC - 2));
  endfunction

  task automatic wait_ready(input logic level);
    int n;
    n = 0;
    while (ready_o !== level) begin
      @(negedge clk);
      n++;
      if (n > WAIT_LIMIT) begin
        report_failure($sformatf("Timeout in %s waiting for ready_o to go %0b",
                                 test_name, level));
      end
    end
  endtask

  task automatic run_frame();
    int n;
    int low;
    start_i = 1'b1;
    @(negedge clk);
    start_i = 1'b0;
    wait_ready(1'b0); // Clear running
    low = 0;
    while (ready_o !== 1'b1) begin
      low++;
      @(negedge clk);
      if (low > WAIT_LIMIT) report_failure({"ready_o never rose after the clear in ", test_name});
    end
    check_count("ready_o low cycles", count_t'(CLEAR_CYCLES), count_t'(low));
    for (int r = 0; r < `IMG_ROWS; r++) begin
      for (int c = 0; c < `IMG_COLS; c++) begin
        if (ready_o !== 1'b1) report_failure("ready_o dropped while pixels were being fed");
        pixel_i = img[r][c];
        pixel_valid_i = 1'b1;
        @(negedge clk);
      end
    end
    pixel_valid_i = 1'b0;
    n = 0;
    while (frame_done_o !== 1'b1) begin
      @(negedge clk);
      n++;
      if (n > WAIT_LIMIT) report_failure({"Timeout waiting for frame_done_o in ", test_name});
    end
    @(negedge clk);
    check_flag("frame_done_o single pulse", 1'b0, frame_done_o);
  endtask

  task automatic read_hist(input bit toggle_en);
    int issued;
    int n;
    int target;
    issued = 0;
    n = 0;
    target = reads_done + 1;
    while (issued < NBINS) begin
      read_en_i = toggle_en ? ($urandom_range(1, 0) == 1) : 1'b1;
      if (read_en_i) issued++;
      @(negedge clk);
      n++;
      if (n > WAIT_LIMIT) report_failure({"Read-out did not finish in ", test_name});
    end
    read_en_i = 1'b0;
    n = 0;
    while (reads_done < target) begin
      @(negedge clk);
      n++;
      if (n > 50) report_failure({"read_done_o never came after the last bin in ", test_name});
    end
    check_count("bin total", count_t'((MR - 2) * (MC - 2)), frame_sum);
  endtask

  always @(posedge clk) begin
    en_q <= read_en_i;
  end

  // Outputs are stable at the falling edge
  always @(negedge clk) begin
    if (rst_n) begin
      check_flag("hist_valid_o", en_q, hist_valid_o);
      check_flag("read_done_o", done_due, read_done_o);
      done_due = 1'b0;
      if (read_done_o) reads_done++;
      if (hist_valid_o) begin
        exp_bin.f.ci = 1'(bin_idx / (`RIU2_CODES * `RIU2_CODES));
        exp_bin.f.ni = riu2_t'((bin_idx / `RIU2_CODES) % `RIU2_CODES);
        exp_bin.f.rd = riu2_t'(bin_idx % `RIU2_CODES);
        check_bin(exp_bin, bin_o);
        check_count("count_o", exp_hist[exp_bin.addr], count_o);
        frame_sum = (bin_idx == 0) ? count_o : frame_sum + count_o;
        if (bin_idx == NBINS - 1) begin
          bin_idx = 0;
          done_due = 1'b1;
        end else begin
          bin_idx++;
        end
      end
    end
  end

  initial begin
    void'($urandom(32'h4fd7_68d7));
    rst_n = 1'b0;
    pixel_i = '0;
    pixel_valid_i = 1'b0;
    start_i = 1'b0;
    read_en_i = 1'b0;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_flag("ready_o after reset", 1'b1, ready_o);
    check_flag("frame_done_o after reset", 1'b0, frame_done_o);

    test_name = "random_frame";
    fill_image(1'b1, '0);
    build_reference();
    run_frame();
    read_hist(1'b0);

    test_name = "flat_frame";
    fill_image(1'b0, 8'h5a);
    expect_flat();
    run_frame();
    read_hist(1'b0);

    test_name = "isolated_pixel";
    fill_image(1'b0, 8'h40);
    img[7][9] = 8'hff;  // Median removes it
    expect_flat();
    run_frame();
    read_hist(1'b0);

    test_name = "read_enable_toggle";
    fill_image(1'b1, '0);
    build_reference();
    run_frame();
    read_hist(1'b1);

    test_name = "second_frame";
    fill_image(1'b1, '0);
    build_reference();
    run_frame();
    read_hist(1'b0);

    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

/* src/code_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface code_if;
  import code_pkg::*;

  logic       valid;
  joint_bin_u bin;
  logic       last;  // Final code of the frame
  logic       ready; // Low during histogram clear

  modport src (output valid, output bin, output last, input ready);
  modport dst (input valid, input bin, input last, output ready);

endinterface

`default_nettype wire

/* src/code_pkg.sv */
`default_nettype none
`include "texture_params.svh"

package code_pkg;

  localparam int BIN_W = 9;

  typedef logic [3:0] riu2_t;

  typedef struct packed {
    logic  ci;
    riu2_t ni;
    riu2_t rd;
  } joint_fields_t;

  // Same bin word seen as memory address or as code fields
  typedef union packed {
    logic [BIN_W-1:0] addr;
    joint_fields_t    f;
  } joint_bin_u;

  typedef logic [`CNT_W-1:0] count_t;

endpackage

`default_nettype wire

/* src/hist_reader.sv */
`timescale 1ns/1ps
`default_nettype none
`include "texture_params.svh"

module hist_reader (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 start_i,
  input  logic                 read_en_i,
  output logic                 clear_o,
  output logic                 rd_req_o,
  output code_pkg::joint_bin_u rd_bin_o,
  output code_pkg::joint_bin_u bin_o,
  input  code_pkg::count_t     count_i,
  output code_pkg::count_t     count_o,
  output logic                 hist_valid_o,
  output logic                 read_done_o,
  output logic                 frame_start_o
);
  import code_pkg::*;

  localparam riu2_t RIU2_MAX = riu2_t'(`RIU2_CODES - 1);

  logic start_q;
  logic active; // Bins left to issue
  logic last_bin;
  logic last_q;

  assign frame_start_o = start_q & ~start_i;
  assign rd_req_o = read_en_i & active;
  assign last_bin = rd_bin_o.f.ci && (rd_bin_o.f.ni == RIU2_MAX) && (rd_bin_o.f.rd == RIU2_MAX);
  assign count_o = hist_valid_o ? count_i : '0;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      start_q      <= 1'b0;
      clear_o      <= 1'b0;
      active       <= 1'b0;
      rd_bin_o     <= '0;
      hist_valid_o <= 1'b0;
      last_q       <= 1'b0;
      read_done_o  <= 1'b0;
    end else begin
      start_q      <= start_i;
      clear_o      <= frame_start_o;
      hist_valid_o <= rd_req_o;
      last_q       <= rd_req_o & last_bin;
      read_done_o  <= last_q;
      if (frame_start_o) begin
        active   <= 1'b1;
        rd_bin_o <= '0;
      end else if (rd_req_o) begin
        if (rd_bin_o.f.rd != RIU2_MAX) begin
          rd_bin_o.f.rd <= rd_bin_o.f.rd + 1'b1;
        end else begin
          rd_bin_o.f.rd <= '0;
          if (rd_bin_o.f.ni != RIU2_MAX) begin
            rd_bin_o.f.ni <= rd_bin_o.f.ni + 1'b1;
          end else begin
            rd_bin_o.f.ni <= '0;
            rd_bin_o.f.ci <= 1'b1;
            active        <= ~rd_bin_o.f.ci; // Stops after ci=1 half
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_req_o) begin
      bin_o <= rd_bin_o;
    end
  end

endmodule

`default_nettype wire

/* src/joint_histogram.sv */
`timescale 1ns/1ps
`default_nettype none

module joint_histogram (
  input  logic                clk,
  input  logic                rst_n,
  code_if.dst                 code,
  input  logic                clear_i,
  input  logic                rd_req_i,
  input  code_pkg::joint_bin_u rd_bin_i,
  output code_pkg::count_t    rd_count_o,
  output logic                frame_done_o
);
  import code_pkg::*;

  localparam int DEPTH = 2 ** BIN_W;

  count_t           mem [DEPTH];
  logic             clr_busy;
  logic [BIN_W-1:0] clr_addr;
  logic             s1_valid;
  logic             s1_last;
  logic [BIN_W-1:0] s1_addr;
  count_t           s1_base; // Count before this code
  count_t           s1_next;
  logic             fwd;

  assign code.ready = ~clr_busy;
  assign s1_next = (s1_base == '1) ? s1_base : s1_base + 1'b1; // Saturate
  assign fwd = s1_valid && (s1_addr == code.bin.addr); // Write still pending

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      clr_busy     <= 1'b0;
      clr_addr     <= '0;
      s1_valid     <= 1'b0;
      s1_last      <= 1'b0;
      frame_done_o <= 1'b0;
    end else begin
      s1_valid     <= code.valid;
      s1_last      <= code.valid & code.last;
      frame_done_o <= s1_valid & s1_last;
      if (clear_i) begin
        clr_busy <= 1'b1;
        clr_addr <= '0;
      end else if (clr_busy) begin
        clr_addr <= clr_addr + 1'b1;
        if (clr_addr == '1) begin
          clr_busy <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (clr_busy) begin
      mem[clr_addr] <= '0;
    end else if (s1_valid) begin
      mem[s1_addr] <= s1_next;
    end
    if (code.valid) begin
      s1_addr <= code.bin.addr;
      s1_base <= fwd ? s1_next : mem[code.bin.addr];
    end
    if (rd_req_i) begin
      rd_count_o <= mem[rd_bin_i.addr];
    end
  end

endmodule

`default_nettype wire

/* src/lbp_coder.sv */
`timescale 1ns/1ps
`default_nettype none
`include "texture_params.svh"

module lbp_coder (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            valid_i,
  input  pix_pkg::pixel_t med_i,
  input  logic            last_i,
  input  logic            frame_start_i,
  code_if.src             code
);
  import pix_pkg::*;
  import code_pkg::*;

  localparam riu2_t NON_UNIFORM = riu2_t'(`RIU2_CODES - 1);

  logic              win_valid;
  window_t           win;
  logic [1:0]        last_d; // Median last pixel, aligned to the window output
  pixel_t [7:0]      ring;
  logic [`PIX_W+2:0] nb_sum;
  pixel_t            nb_mean;
  logic [7:0]        ni_pat, rd_pat;
  logic              s1_valid, s1_last, s1_ci;
  logic [7:0]        s1_ni_pat, s1_rd_pat;
  joint_bin_u        bin_d;

  function automatic riu2_t riu2(input logic [7:0] pat);
    logic [3:0] trans;
    logic [3:0] ones;
    trans = '0;
    ones  = '0;
    for (int k = 0; k < 8; k++) begin
      trans = trans + 4'(pat[k] ^ pat[(k + 1) % 8]);
      ones  = ones + 4'(pat[k]);
    end
    return (trans <= 4'd2) ? ones : NON_UNIFORM;
  endfunction

  window_3x3 #(.LINE(`IMG_COLS - 2)) u_win (
    .clk, .rst_n, .valid_i, .pix_i(med_i), .frame_start_i,
    .valid_o(win_valid), .win_o(win), .last_o()
  );

  // Neighbours clockwise from top left
  assign ring = {win[3], win[6], win[7], win[8], win[5], win[2], win[1], win[0]};
  assign nb_mean = nb_sum[`PIX_W+2:3];

  always_comb begin
    nb_sum = '0;
    for (int k = 0; k < 8; k++) begin
      nb_sum = nb_sum + ring[k];
    end
    for (int k = 0; k < 8; k++) begin
      rd_pat[k] = ring[k] >= win[4];
      ni_pat[k] = ring[k] >= nb_mean;
    end
    bin_d.f.ci = s1_ci;
    bin_d.f.ni = riu2(s1_ni_pat);
    bin_d.f.rd = riu2(s1_rd_pat);
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      last_d     <= '0;
      s1_valid   <= 1'b0;
      s1_last    <= 1'b0;
      code.valid <= 1'b0;
      code.last  <= 1'b0;
    end else begin
      last_d     <= {last_d[0], valid_i & last_i};
      s1_valid   <= win_valid & code.ready; // Pipeline flushes while a clear runs
      s1_last    <= win_valid & code.ready & last_d[1];
      code.valid <= s1_valid & code.ready;
      code.last  <= s1_valid & code.ready & s1_last;
    end
  end

  always_ff @(posedge clk) begin
    if (win_valid) begin
      s1_ci     <= win[4] >= nb_mean;
      s1_ni_pat <= ni_pat;
      s1_rd_pat <= rd_pat;
    end
    if (s1_valid) begin
      code.bin <= bin_d;
    end
  end

endmodule

`default_nettype wire

/* src/median_filter.sv */
`timescale 1ns/1ps
`default_nettype none
`include "texture_params.svh"

module median_filter (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            valid_i,
  input  pix_pkg::pixel_t pix_i,
  input  logic            frame_start_i,
  output logic            valid_o,
  output pix_pkg::pixel_t med_o,
  output logic            last_o
);
  import pix_pkg::*;

  logic    win_valid;
  logic    win_last;
  window_t win;
  pixel_t  lo [3];
  pixel_t  mi [3];
  pixel_t  hi [3];
  pixel_t  s1_lo, s1_mi, s1_hi;
  logic    s1_valid, s1_last;

  function automatic pixel_t min2(input pixel_t a, input pixel_t b);
    return (a < b) ? a : b;
  endfunction

  function automatic pixel_t max2(input pixel_t a, input pixel_t b);
    return (a > b) ? a : b;
  endfunction

  function automatic pixel_t med3(input pixel_t a, input pixel_t b, input pixel_t c);
    return max2(min2(a, b), min2(max2(a, b), c));
  endfunction

  window_3x3 #(.LINE(`IMG_COLS)) u_win (
    .clk, .rst_n, .valid_i, .pix_i, .frame_start_i,
    .valid_o(win_valid), .win_o(win), .last_o(win_last)
  );

  // Sort each row
  always_comb begin
    for (int r = 0; r < 3; r++) begin
      lo[r] = min2(win[3*r], min2(win[3*r+1], win[3*r+2]));
      mi[r] = med3(win[3*r], win[3*r+1], win[3*r+2]);
      hi[r] = max2(win[3*r], max2(win[3*r+1], win[3*r+2]));
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
      s1_last  <= 1'b0;
      valid_o  <= 1'b0;
      last_o   <= 1'b0;
    end else begin
      s1_valid <= win_valid;
      s1_last  <= win_valid & win_last;
      valid_o  <= s1_valid;
      last_o   <= s1_last;
    end
  end

  always_ff @(posedge clk) begin
    s1_lo <= max2(lo[0], max2(lo[1], lo[2])); // Largest of the row minima
    s1_mi <= med3(mi[0], mi[1], mi[2]);
    s1_hi <= min2(hi[0], min2(hi[1], hi[2]));
    med_o <= med3(s1_lo, s1_mi, s1_hi);
  end

endmodule

`default_nettype wire

/* src/pix_pkg.sv */
`default_nettype none
`include "texture_params.svh"

package pix_pkg;

  typedef logic [`PIX_W-1:0] pixel_t;

  // Raster order, index 4 is the centre
  typedef pixel_t [8:0] window_t;

endpackage

`default_nettype wire

/* src/texture_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "texture_params.svh"

module texture_top (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [`PIX_W-1:0]          pixel_i,
  input  logic                       pixel_valid_i,
  input  logic                       start_i,
  input  logic                       read_en_i,
  output logic                       ready_o,
  output logic                       frame_done_o,
  output logic [code_pkg::BIN_W-1:0] bin_o,
  output logic [`CNT_W-1:0]          count_o,
  output logic                       hist_valid_o,
  output logic                       read_done_o
);
  import pix_pkg::*;
  import code_pkg::*;

  code_if     cif ();
  logic       pix_valid;
  logic       med_valid, med_last;
  pixel_t     med_pix;
  logic       frame_start, clear;
  logic       rd_req;
  joint_bin_u rd_bin;
  count_t     rd_count;

  assign pix_valid = pixel_valid_i & cif.ready; // Pixels dropped during clear
  assign ready_o = cif.ready;

  median_filter u_median (
    .clk, .rst_n, .valid_i(pix_valid), .pix_i(pixel_i), .frame_start_i(frame_start),
    .valid_o(med_valid), .med_o(med_pix), .last_o(med_last)
  );

  lbp_coder u_coder (
    .clk, .rst_n, .valid_i(med_valid), .med_i(med_pix), .last_i(med_last),
    .frame_start_i(frame_start), .code(cif.src)
  );

  joint_histogram u_hist (
    .clk, .rst_n, .code(cif.dst), .clear_i(clear), .rd_req_i(rd_req),
    .rd_bin_i(rd_bin), .rd_count_o(rd_count), .frame_done_o
  );

  hist_reader u_reader (
    .clk, .rst_n, .start_i, .read_en_i, .clear_o(clear), .rd_req_o(rd_req),
    .rd_bin_o(rd_bin), .bin_o, .count_i(rd_count), .count_o,
    .hist_valid_o, .read_done_o, .frame_start_o(frame_start)
  );

endmodule

`default_nettype wire

/* src/window_3x3.sv */
`timescale 1ns/1ps
`default_nettype none
`include "texture_params.svh"

module window_3x3 #(
  parameter int LINE = `IMG_COLS
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             valid_i,
  input  pix_pkg::pixel_t  pix_i,
  input  logic             frame_start_i,
  output logic             valid_o,
  output pix_pkg::window_t win_o,
  output logic             last_o
);
  import pix_pkg::*;

  // A narrower line means an earlier stage already trimmed both directions
  localparam int ROWS = `IMG_ROWS - (`IMG_COLS - LINE);
  localparam int CW = $clog2(LINE);
  localparam int RW = $clog2(ROWS);

  pixel_t       lb0 [LINE]; // Row above
  pixel_t       lb1 [LINE]; // Two rows above
  pixel_t [2:0] col_q;      // New column, top first
  logic [CW-1:0] col;
  logic [RW-1:0] row;
  logic          col_v;
  logic          col_int;
  logic          col_last;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col      <= '0;
      row      <= '0;
      col_v    <= 1'b0;
      col_int  <= 1'b0;
      col_last <= 1'b0;
      valid_o  <= 1'b0;
      last_o   <= 1'b0;
    end else begin
      col_v    <= valid_i & ~frame_start_i;
      col_int  <= (row >= RW'(2)) && (col >= CW'(2)); // Centre off the border
      col_last <= (row == RW'(ROWS - 1)) && (col == CW'(LINE - 1));
      valid_o  <= col_v & col_int;
      last_o   <= col_v & col_last;
      if (frame_start_i) begin
        col <= '0;
        row <= '0;
      end else if (valid_i) begin
        col <= (col == CW'(LINE - 1)) ? '0 : col + 1'b1;
        if (col == CW'(LINE - 1)) begin
          row <= (row == RW'(ROWS - 1)) ? '0 : row + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (valid_i) begin
      lb0[col] <= pix_i;
      lb1[col] <= lb0[col];
      col_q    <= {pix_i, lb0[col], lb1[col]};
    end
    if (col_v) begin
      for (int r = 0; r < 3; r++) begin
        win_o[3*r]   <= win_o[3*r+1];
        win_o[3*r+1] <= win_o[3*r+2];
        win_o[3*r+2] <= col_q[r];
      end
    end
  end

endmodule

`default_nettype wire
